// File: include/udp_echo_macros.svh
/*
 * UDP echo core constants
 * Echo port, local IP address, reply TTL and payload FIFO depth
 */

`ifndef UDP_ECHO_MACROS_SVH
`define UDP_ECHO_MACROS_SVH

// Destination port that gets an echo reply
`define UDP_ECHO_PORT 16'd1234

// Local address 192.168.1.128, used as the reply source
`define UDP_LOCAL_IP 32'hC0A8_0180

// TTL placed in every reply header
`define UDP_REPLY_TTL 8'd64

// Payload FIFO depth in beats, power of two
`define UDP_FIFO_DEPTH 8192

`endif

// File: src/udp_echo_pkg.sv
/*
 * Shared types for the UDP echo core
 * UDP/IP header word and single-byte payload beat
 */

`default_nettype none

package udp_echo_pkg;

    // Decoded UDP header with the IP fields the echo needs
    // Same layout for received and reply headers
    typedef struct packed {
        logic [5:0]  ip_dscp;
        logic [1:0]  ip_ecn;
        logic [7:0]  ip_ttl;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // One payload byte with its frame marks
    typedef struct packed {
        logic [7:0] data;
        // End of frame
        logic       last;
        // Error mark, passed through untouched
        logic       user;
    } axis_byte_t;

endpackage

`default_nettype wire

// File: src/udp_header_router.sv
/*
 * UDP header router
 * Port match, header accept rule and reply header construction
 */

`timescale 1ns/1ps
`default_nettype none

`include "udp_echo_macros.svh"

module udp_header_router (
    input  wire                      clk,
    input  wire                      rst,

    input  wire udp_echo_pkg::udp_hdr_t rx_hdr,
    input  wire                      rx_hdr_valid,
    output logic                     rx_hdr_ready,

    output udp_echo_pkg::udp_hdr_t   tx_hdr,
    output logic                     tx_hdr_valid,
    input  wire                      tx_hdr_ready,

    input  wire                      gate_busy,

    output logic                     route_load,
    output logic                     route_echo
);

    logic run;
    logic port_match;
    logic accept_ok;

    // Header path stays closed until the cycle after reset releases,
    // so no header is taken while the payload gate is still held idle
    always_ff @(posedge clk) begin
        if (rst) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    assign port_match = (rx_hdr.dest_port == `UDP_ECHO_PORT);

    // One frame at a time through the payload gate
    assign accept_ok = run && !gate_busy;

    // Matching headers go straight through, others are swallowed
    assign tx_hdr_valid = rx_hdr_valid && port_match && accept_ok;
    assign rx_hdr_ready = accept_ok && (port_match ? tx_hdr_ready : 1'b1);

    // Route decision handed to the gate with each accepted header
    assign route_load = rx_hdr_valid && rx_hdr_ready;
    assign route_echo = port_match;

    // Reply header
    always_comb begin
        tx_hdr.ip_dscp     = 6'd0;
        tx_hdr.ip_ecn      = 2'd0;
        tx_hdr.ip_ttl      = `UDP_REPLY_TTL;
        tx_hdr.source_ip   = `UDP_LOCAL_IP;
        tx_hdr.dest_ip     = rx_hdr.source_ip;
        // Ports swapped
        tx_hdr.source_port = rx_hdr.dest_port;
        tx_hdr.dest_port   = rx_hdr.source_port;
        tx_hdr.length      = rx_hdr.length;
        tx_hdr.checksum    = 16'd0;
    end

endmodule

`default_nettype wire

// File: src/udp_payload_gate.sv
/*
 * UDP payload gate
 * Per-frame route register steering payload beats to the FIFO or to discard
 */

`timescale 1ns/1ps
`default_nettype none

module udp_payload_gate (
    input  wire                          clk,
    input  wire                          rst,

    input  wire                          route_load,
    input  wire                          route_echo,
    output logic                         busy,

    input  wire udp_echo_pkg::axis_byte_t rx_payload,
    input  wire                          rx_payload_valid,
    output logic                         rx_payload_ready,

    output udp_echo_pkg::axis_byte_t     fifo_in,
    output logic                         fifo_in_valid,
    input  wire                          fifo_in_ready
);

    typedef enum logic [1:0] {
        GATE_IDLE    = 2'd0,
        GATE_PASS    = 2'd1,
        GATE_DISCARD = 2'd2
    } gate_state_t;

    gate_state_t state;
    logic        last_xfer;

    assign last_xfer = rx_payload_valid && rx_payload_ready && rx_payload.last;

    // Route is taken once per header and held until the frame ends
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= GATE_IDLE;
        end else begin
            case (state)
                GATE_IDLE: begin
                    if (route_load) begin
                        state <= route_echo ? GATE_PASS : GATE_DISCARD;
                    end
                end
                GATE_PASS, GATE_DISCARD: begin
                    if (last_xfer) begin
                        state <= GATE_IDLE;
                    end
                end
                default: state <= GATE_IDLE;
            endcase
        end
    end

    assign busy = (state != GATE_IDLE);

    // Beats only reach the FIFO while passing
    assign fifo_in       = rx_payload;
    assign fifo_in_valid = rx_payload_valid && (state == GATE_PASS);

    // Discarded frames drain at full rate
    assign rx_payload_ready = (state == GATE_PASS) ? fifo_in_ready : (state == GATE_DISCARD);

endmodule

`default_nettype wire

// File: src/payload_fifo.sv
/*
 * Payload FIFO
 * Synchronous first-word-fall-through buffer for payload beats
 */

`timescale 1ns/1ps
`default_nettype none

`include "udp_echo_macros.svh"

module payload_fifo #(
    parameter int DEPTH = `UDP_FIFO_DEPTH
) (
    input  wire                          clk,
    input  wire                          rst,

    input  wire udp_echo_pkg::axis_byte_t in_beat,
    input  wire                          in_valid,
    output logic                         in_ready,

    output udp_echo_pkg::axis_byte_t     out_beat,
    output logic                         out_valid,
    input  wire                          out_ready
);

    localparam int AW = $clog2(DEPTH);

    udp_echo_pkg::axis_byte_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          empty;
    logic          do_write;
    logic          do_read;

    assign full  = (count == (AW+1)'(DEPTH));
    assign empty = (count == '0);

    assign in_ready  = !full;
    assign out_valid = !empty;

    assign do_write = in_valid && in_ready;
    assign do_read  = out_valid && out_ready;

    // Storage
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    // Head of the queue is always on the output
    assign out_beat = mem[rd_ptr];

    // Pointers wrap naturally at a power-of-two depth
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/first_byte_led.sv
/*
 * First byte LED latch
 * Captures the first data byte of each transferred frame
 */

`timescale 1ns/1ps
`default_nettype none

module first_byte_led (
    input  wire                          clk,
    input  wire                          rst,

    input  wire udp_echo_pkg::axis_byte_t beat,
    input  wire                          beat_valid,
    input  wire                          beat_ready,

    output logic [7:0]                   led
);

    logic armed;
    logic xfer;

    assign xfer = beat_valid && beat_ready;

    // Armed means the next transfer starts a frame
    always_ff @(posedge clk) begin
        if (rst) begin
            armed <= 1'b1;
            led   <= 8'd0;
        end else if (xfer) begin
            if (armed) begin
                led <= beat.data;
            end
            armed <= beat.last;
        end
    end

endmodule

`default_nettype wire

// File: src/udp_echo_top.sv
/*
 * UDP echo core top level
 * Header router, payload gate, payload FIFO and LED latch
 */

`timescale 1ns/1ps
`default_nettype none

module udp_echo_top (
    input  wire                          clk,
    input  wire                          rst,

    // Received frame
    input  wire udp_echo_pkg::udp_hdr_t   rx_hdr,
    input  wire                          rx_hdr_valid,
    output logic                         rx_hdr_ready,
    input  wire udp_echo_pkg::axis_byte_t rx_payload,
    input  wire                          rx_payload_valid,
    output logic                         rx_payload_ready,

    // Reply frame
    output udp_echo_pkg::udp_hdr_t       tx_hdr,
    output logic                         tx_hdr_valid,
    input  wire                          tx_hdr_ready,
    output udp_echo_pkg::axis_byte_t     tx_payload,
    output logic                         tx_payload_valid,
    input  wire                          tx_payload_ready,

    output logic [7:0]                   led
);

    logic                     route_load;
    logic                     route_echo;
    logic                     gate_busy;
    udp_echo_pkg::axis_byte_t fifo_in;
    logic                     fifo_in_valid;
    logic                     fifo_in_ready;

    udp_header_router u_router (
        .clk          (clk),
        .rst          (rst),
        .rx_hdr       (rx_hdr),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .tx_hdr       (tx_hdr),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .gate_busy    (gate_busy),
        .route_load   (route_load),
        .route_echo   (route_echo)
    );

    udp_payload_gate u_gate (
        .clk              (clk),
        .rst              (rst),
        .route_load       (route_load),
        .route_echo       (route_echo),
        .busy             (gate_busy),
        .rx_payload       (rx_payload),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .fifo_in          (fifo_in),
        .fifo_in_valid    (fifo_in_valid),
        .fifo_in_ready    (fifo_in_ready)
    );

    // Echo payload buffer
    payload_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (fifo_in),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .out_beat  (tx_payload),
        .out_valid (tx_payload_valid),
        .out_ready (tx_payload_ready)
    );

    // Watches the outgoing payload handshake
    first_byte_led u_led (
        .clk        (clk),
        .rst        (rst),
        .beat       (tx_payload),
        .beat_valid (tx_payload_valid),
        .beat_ready (tx_payload_ready),
        .led        (led)
    );

endmodule

`default_nettype wire

// File: testbench/tb_udp_echo.sv
/*
 * Testbench for the UDP echo core
 * Frame driver, reply monitors, compare tasks and cycle limit
 */

`timescale 1ns/1ps
`default_nettype none

`include "udp_echo_macros.svh"

module tb_udp_echo;

    logic                     clk = 1'b0;
    logic                     rst;
    udp_echo_pkg::udp_hdr_t   rx_hdr;
    logic                     rx_hdr_valid;
    logic                     rx_hdr_ready;
    udp_echo_pkg::axis_byte_t rx_payload;
    logic                     rx_payload_valid;
    logic                     rx_payload_ready;
    udp_echo_pkg::udp_hdr_t   tx_hdr;
    logic                     tx_hdr_valid;
    logic                     tx_hdr_ready;
    udp_echo_pkg::axis_byte_t tx_payload;
    logic                     tx_payload_valid;
    logic                     tx_payload_ready;
    logic [7:0]               led;

    // Frame table from the stimulus file
    logic [15:0] f_dport[$];
    logic [15:0] f_sport[$];
    logic [31:0] f_sip[$];
    logic [15:0] f_len[$];
    int          f_cnt[$];
    bit          f_echo[$];
    logic [7:0]  f_led[$];
    logic [7:0]  f_bytes[$];

    // Transfers seen on the reply side
    udp_echo_pkg::udp_hdr_t   got_hdr[$];
    udp_echo_pkg::axis_byte_t got_beat[$];

    int errors = 0;
    int tests = 0;
    int cycles = 0;
    int cycle_limit = 0;

    udp_echo_top DUT (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_payload       (rx_payload),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .tx_hdr           (tx_hdr),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_payload       (tx_payload),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .led              (led)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // Random back-pressure on both reply channels
    always @(posedge clk) begin
        tx_hdr_ready     <= ($urandom % 4) != 0;
        tx_payload_ready <= ($urandom % 3) != 0;
    end

    always @(posedge clk) begin
        if (!rst && tx_hdr_valid && tx_hdr_ready) begin
            got_hdr.push_back(tx_hdr);
        end
    end

    always @(posedge clk) begin
        if (!rst && tx_payload_valid && tx_payload_ready) begin
            got_beat.push_back(tx_payload);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, replies never completed", cycles);
            $display("tests failed");
            $finish;
        end
    end

    task automatic check_hdr(input udp_echo_pkg::udp_hdr_t got,
                             input udp_echo_pkg::udp_hdr_t want);
        if (got !== want) begin
            $display("[ERROR] tx_hdr got 0x%h expected 0x%h", got, want);
            errors++;
        end
    endtask

    task automatic check_beat(input udp_echo_pkg::axis_byte_t got,
                              input udp_echo_pkg::axis_byte_t want);
        if (got !== want) begin
            $display("[ERROR] tx_payload got 0x%h expected 0x%h", got, want);
            errors++;
        end
    endtask

    task automatic check_led(input logic [7:0] got, input logic [7:0] want);
        if (got !== want) begin
            $display("[ERROR] led got 0x%h expected 0x%h", got, want);
            errors++;
        end
    endtask

    task automatic load_stimulus(output bit ok);
        int          fd;
        int          fields;
        int          byte_val;
        int          cnt;
        string       line;
        string       kind;
        logic [15:0] dport;
        logic [15:0] sport;
        logic [31:0] sip;
        logic [15:0] len;
        logic [7:0]  led_val;
        ok = 1'b0;
        fd = $fopen("testbench/udp_echo_stimulus.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fgets(line, fd) != 0) begin
                // Comments and the line ends left after payload bytes
                if (line.len() < 4 || line[0] == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%h %h %h %h %d %s %h",
                                 dport, sport, sip, len, cnt, kind, led_val);
                if (fields != 7 || cnt < 1) begin
                    ok = 1'b0;
                    break;
                end
                f_dport.push_back(dport);
                f_sport.push_back(sport);
                f_sip.push_back(sip);
                f_len.push_back(len);
                f_cnt.push_back(cnt);
                f_echo.push_back(kind == "E");
                f_led.push_back(led_val);
                for (int i = 0; i < cnt; i++) begin
                    if ($fscanf(fd, "%h", byte_val) != 1) begin
                        ok = 1'b0;
                    end
                    f_bytes.push_back(byte_val[7:0]);
                end
                cycle_limit += 100 + 20 * cnt;
            end
            $fclose(fd);
        end
        if (f_cnt.size() == 0) begin
            ok = 1'b0;
        end
    endtask

    task automatic check_idle();
        int errs_before;
        errs_before = errors;
        repeat (6) begin
            @(negedge clk);
            if (tx_hdr_valid || tx_payload_valid) begin
                $display("Reply valid raised before any header was sent");
                errors++;
            end
            if (rx_payload_ready) begin
                $display("Payload ready raised while no frame was open");
                errors++;
            end
            check_led(led, 8'h00);
        end
        tests++;
        $display("idle after reset: %s", (errors == errs_before) ? "ok" : "FAILED");
    endtask

    task automatic send_hdr(input udp_echo_pkg::udp_hdr_t h);
        @(posedge clk);
        rx_hdr       <= h;
        rx_hdr_valid <= 1'b1;
        do @(posedge clk); while (!rx_hdr_ready);
        rx_hdr_valid <= 1'b0;
    endtask

    task automatic send_beat(input udp_echo_pkg::axis_byte_t b);
        rx_payload       <= b;
        rx_payload_valid <= 1'b1;
        do @(posedge clk); while (!rx_payload_ready);
    endtask

    task automatic run_frame(input int idx, input int base);
        udp_echo_pkg::udp_hdr_t   rx_h;
        udp_echo_pkg::udp_hdr_t   exp_h;
        udp_echo_pkg::axis_byte_t exp_q[$];
        udp_echo_pkg::axis_byte_t b;
        int                       n;
        int                       errs_before;
        n = f_cnt[idx];
        errs_before = errors;
        // Received IP fields all differ from the reply so each rewrite is visible
        rx_h.ip_dscp     = 6'h2e;
        rx_h.ip_ecn      = 2'd1;
        rx_h.ip_ttl      = 8'd17;
        rx_h.source_ip   = f_sip[idx];
        rx_h.dest_ip     = 32'($urandom);
        rx_h.source_port = f_sport[idx];
        rx_h.dest_port   = f_dport[idx];
        rx_h.length      = f_len[idx];
        rx_h.checksum    = 16'($urandom);
        // Reply: ports swapped, back to sender, fixed TTL, cleared fields
        exp_h.ip_dscp     = 6'd0;
        exp_h.ip_ecn      = 2'd0;
        exp_h.ip_ttl      = `UDP_REPLY_TTL;
        exp_h.source_ip   = `UDP_LOCAL_IP;
        exp_h.dest_ip     = f_sip[idx];
        exp_h.source_port = f_dport[idx];
        exp_h.dest_port   = f_sport[idx];
        exp_h.length      = f_len[idx];
        exp_h.checksum    = 16'd0;
        send_hdr(rx_h);
        for (int i = 0; i < n; i++) begin
            b.data = f_bytes[base + i];
            b.last = (i == n - 1);
            b.user = 1'($urandom % 2);
            exp_q.push_back(b);
            send_beat(b);
        end
        rx_payload_valid <= 1'b0;
        if (f_echo[idx]) begin
            do @(negedge clk); while (got_hdr.size() < 1 || got_beat.size() < n);
            if (got_hdr.size() != 1 || got_beat.size() != n) begin
                $display("Frame %0d reply has %0d headers and %0d beats, wanted 1 and %0d",
                         idx, got_hdr.size(), got_beat.size(), n);
                errors++;
            end else begin
                check_hdr(got_hdr[0], exp_h);
                for (int i = 0; i < n; i++) begin
                    check_beat(got_beat[i], exp_q[i]);
                end
            end
        end else begin
            repeat (4) @(negedge clk);
            if (got_hdr.size() != 0 || got_beat.size() != 0) begin
                $display("Dropped frame %0d produced reply output", idx);
                errors++;
            end
        end
        got_hdr.delete();
        got_beat.delete();
        check_led(led, f_led[idx]);
        tests++;
        $display("frame %0d %s: %s", idx, f_echo[idx] ? "echo" : "drop",
                 (errors == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        bit loaded;
        int base;
        rst              = 1'b1;
        rx_hdr           = '0;
        rx_hdr_valid     = 1'b0;
        rx_payload       = '0;
        rx_payload_valid = 1'b0;
        tx_hdr_ready     = 1'b0;
        tx_payload_ready = 1'b0;
        void'($urandom(32'h9359_c633));
        load_stimulus(loaded);
        if (!loaded) begin
            $display("Stimulus file missing or malformed, nothing was run");
            $display("tests failed");
            $finish;
        end else begin
            repeat (3) @(posedge clk);
            rst <= 1'b0;
            check_idle();
            base = 0;
            for (int i = 0; i < f_cnt.size(); i++) begin
                run_frame(i, base);
                base += f_cnt[i];
            end
            $display("%0d tests run, %0d errors", tests, errors);
            if (errors == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: testbench/udp_echo_stimulus.txt
# dest_port src_port src_ip length nbytes outcome(E echo, D drop) led_after, all hex but nbytes
# payload bytes in hex follow on the next lines
04d2 c350 c0a80105 000c 4 E 11
11 22 33 44
04d2 1f90 c0a8010a 0009 1 E a5
a5
0035 04d2 c0a80102 000e 6 D a5
de ad be ef 00 01
04d2 0400 0a000001 0010 8 E 3c
3c 3d 3e 3f 40 41 42 43
04d3 d431 c0a80107 000b 3 D 3c
77 88 99
0000 ffff c0a80108 0009 1 D 3c
5a
04d2 ea60 c0a80199 0020 24 E 00
00 01 02 03 04 05 06 07 08 09 0a 0b
0c 0d 0e 0f 10 11 12 13 14 15 16 17
04d2 1388 ac100005 000d 5 E ff
ff fe fd fc fb
04d2 04d2 c0a801fe 0012 10 E 80
80 81 82 83 84 85 86 87 88 89
ffff 04d2 c0a80103 000a 2 D 80
12 34
04d2 2710 c0a80120 000b 3 E 69
69 96 c3
04d1 2710 c0a80120 000b 3 D 69
01 02 03
04d2 8001 c0a80133 000e 6 E 5e
5e 00 ff 00 ff e5

// File: project.f
+incdir+include
src/udp_echo_pkg.sv
src/udp_header_router.sv
src/udp_payload_gate.sv
src/payload_fifo.sv
src/first_byte_led.sv
src/udp_echo_top.sv
testbench/tb_udp_echo.sv

// File: Bender.yml
package:
  name: udp_echo

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/udp_echo_pkg.sv
      - src/udp_header_router.sv
      - src/udp_payload_gate.sv
      - src/payload_fifo.sv
      - src/first_byte_led.sv
      - src/udp_echo_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/tb_udp_echo.sv
